/* sync_ctrl_pkg.sv */
// Shared definitions for the SYNC pulse controller
// Counter and divider widths, range and phase types,
// sequencer state encoding and the two inter-block structs

`default_nettype none

package sync_ctrl_pkg;

   //======================================================================
   // Widths
   //======================================================================
   localparam int GATE_W = 8;                // Gate and edge counters
   localparam int DIV_W  = 4;                // Sync clock divide ratio

   //======================================================================
   // Types
   //======================================================================
   typedef logic [GATE_W-1:0] count_t;       // clk_in edges seen in one gate
   typedef logic [2:0]        freq_range_t;  // Range 1 to 5
   typedef logic [DIV_W-1:0]  div_t;         // clk_in cycles per phase step
   typedef logic [2:0]        phase_t;       // 45 degree steps

   // Reconfiguration sequencer
   typedef enum logic [1:0] {
      WAIT_MEAS,                             // Gate still running
      LOAD,                                  // Pick up divide ratio
      LOCK,                                  // Let the divider settle
      READY
   } seq_state_t;

   //======================================================================
   // Inter-block bundles
   //======================================================================
   // Meter to sequencer
   typedef struct packed {
      freq_range_t freq_mode;
      logic        count_done;               // One-cycle strobe
   } meas_t;

   // Sequencer to pulse generator and ready timer
   typedef struct packed {
      div_t        sync_div;
      logic        sync_clk_rdy;             // Level, drp_ref_clk domain
   } sync_cfg_t;

endpackage

`default_nettype wire

/* freq_range_meter.sv */
// Input clock frequency meter
// Counts clk_in rising edges over a gate of drp_ref_clk cycles
// and sorts the count into one of five ranges

`timescale 1ns/1ps
`default_nettype none

module freq_range_meter
   import sync_ctrl_pkg::*;
#(
   parameter int GATE_CYCLES  = 256,
   parameter int R1_MAX_COUNT = 20,
   parameter int R2_MAX_COUNT = 40,
   parameter int R3_MAX_COUNT = 64,
   parameter int R4_MAX_COUNT = 100
) (
   input  logic  drp_ref_clk,
   input  logic  user_reset_n,
   input  logic  clk_in,
   output meas_t meas
);

   logic        clk_meta;        // Two-flop sampler
   logic        clk_sync;
   logic        clk_prev;        // For edge detect
   logic        rise;
   logic        gate_on;
   logic        gate_last;
   count_t      gate_cnt;
   count_t      edge_cnt;
   count_t      edge_next;
   freq_range_t range_next;

   assign rise      = clk_sync & ~clk_prev;
   assign gate_last = gate_on && (gate_cnt == count_t'(GATE_CYCLES - 1));

   // Saturate rather than wrap on a very fast clk_in
   assign edge_next = (rise && (edge_cnt != '1)) ? edge_cnt + count_t'(1) : edge_cnt;

   always_comb begin
      if (edge_next < count_t'(R1_MAX_COUNT))      range_next = 3'd1;
      else if (edge_next < count_t'(R2_MAX_COUNT)) range_next = 3'd2;
      else if (edge_next < count_t'(R3_MAX_COUNT)) range_next = 3'd3;
      else if (edge_next < count_t'(R4_MAX_COUNT)) range_next = 3'd4;
      else                                         range_next = 3'd5;
   end

   //======================================================================
   // Sampling and gate
   //======================================================================
   always_ff @(posedge drp_ref_clk or negedge user_reset_n) begin
      if (!user_reset_n) begin
         clk_meta        <= 1'b0;
         clk_sync        <= 1'b0;
         clk_prev        <= 1'b0;
         gate_on         <= 1'b1;  // Gate opens at reset release
         gate_cnt        <= '0;
         edge_cnt        <= '0;
         meas.count_done <= 1'b0;
         meas.freq_mode  <= 3'd1;
      end else begin
         clk_meta        <= clk_in;
         clk_sync        <= clk_meta;
         clk_prev        <= clk_sync;
         meas.count_done <= gate_last;  // Seen the cycle after the gate
         if (gate_on) begin
            gate_cnt <= gate_cnt + count_t'(1);
            edge_cnt <= edge_next;
            if (gate_last) begin
               gate_on        <= 1'b0;        // Once per reset
               meas.freq_mode <= range_next;  // Range is held from the strobe on
            end
         end
      end
   end

endmodule

`default_nettype wire

/* reconfig_seq.sv */
// Sync clock reconfiguration sequencer
// Waits for the frequency measurement, loads the divide ratio
// for the measured range, waits out the lock time, then flags ready

`timescale 1ns/1ps
`default_nettype none

module reconfig_seq
   import sync_ctrl_pkg::*;
#(
   parameter int RANGE1_DIV  = 1,
   parameter int RANGE2_DIV  = 1,
   parameter int RANGE3_DIV  = 2,
   parameter int RANGE4_DIV  = 3,
   parameter int RANGE5_DIV  = 4,
   parameter int LOCK_CYCLES = 16
) (
   input  logic      drp_ref_clk,
   input  logic      user_reset_n,
   input  meas_t     meas,
   output sync_cfg_t sync_cfg
);

   localparam int LOCK_W = $clog2(LOCK_CYCLES + 1);

   seq_state_t        state;
   logic [LOCK_W-1:0] lock_cnt;
   div_t              div_sel;

   // Divide ratio table, one entry per range
   always_comb begin
      case (meas.freq_mode)
         3'd1:    div_sel = div_t'(RANGE1_DIV);
         3'd2:    div_sel = div_t'(RANGE2_DIV);
         3'd3:    div_sel = div_t'(RANGE3_DIV);
         3'd4:    div_sel = div_t'(RANGE4_DIV);
         default: div_sel = div_t'(RANGE5_DIV);
      endcase
   end

   //======================================================================
   // Sequencer FSM
   //======================================================================
   always_ff @(posedge drp_ref_clk or negedge user_reset_n) begin
      if (!user_reset_n) begin
         state                 <= WAIT_MEAS;
         lock_cnt              <= '0;
         sync_cfg.sync_div     <= div_t'(RANGE1_DIV);  // Keeps the phase counter defined
         sync_cfg.sync_clk_rdy <= 1'b0;
      end else begin
         case (state)
            WAIT_MEAS: begin
               if (meas.count_done)
                  state <= LOAD;
            end
            LOAD: begin
               sync_cfg.sync_div <= div_sel;  // Stable from here until reset
               lock_cnt          <= '0;
               state             <= LOCK;
            end
            LOCK: begin
               lock_cnt <= lock_cnt + LOCK_W'(1);
               if (lock_cnt == LOCK_W'(LOCK_CYCLES - 1)) begin
                  sync_cfg.sync_clk_rdy <= 1'b1;
                  state                 <= READY;
               end
            end
            READY: begin
               sync_cfg.sync_clk_rdy <= 1'b1;  // Held until reset
            end
            default: state <= WAIT_MEAS;
         endcase
      end
   end

endmodule

`default_nettype wire

/* sync_pulse_gen.sv */
// SYNC pulse generator in the clk_in domain
// Phase counter over one sync period, tick at the chosen phase step,
// 2-bit sync counter and the dut_sync register for both modes

`timescale 1ns/1ps
`default_nettype none

module sync_pulse_gen
   import sync_ctrl_pkg::*;
(
   input  logic      clk_in,
   input  logic      user_reset_n,
   input  sync_cfg_t sync_cfg,
   input  logic      sync_en,
   input  logic      sync_mode,   // 0 one-shot, 1 periodic
   input  phase_t    sync_phase,
   output logic      dut_sync
);

   // Sync period is 8 phase steps of sync_div clk_in cycles each
   localparam int PH_W = DIV_W + 3;

   logic            rdy_meta;
   logic            rdy_sync;
   logic [PH_W-1:0] phase_cnt;
   logic [PH_W-1:0] period_last;
   logic [PH_W-1:0] tick_pos;
   logic            tick;
   logic [1:0]      sync_cnt;

   assign period_last = {sync_cfg.sync_div, 3'b000} - PH_W'(1);
   assign tick_pos    = PH_W'(sync_phase) * PH_W'(sync_cfg.sync_div);
   assign tick        = (phase_cnt == tick_pos);

   //======================================================================
   // Ready level into clk_in domain
   //======================================================================
   always_ff @(posedge clk_in or negedge user_reset_n) begin
      if (!user_reset_n) begin
         rdy_meta <= 1'b0;
         rdy_sync <= 1'b0;
      end else begin
         rdy_meta <= sync_cfg.sync_clk_rdy;
         rdy_sync <= rdy_meta;
      end
   end

   //======================================================================
   // Phase counter and sync counter
   //======================================================================
   always_ff @(posedge clk_in or negedge user_reset_n) begin
      if (!user_reset_n) begin
         phase_cnt <= '0;
      end else if (phase_cnt >= period_last) begin
         phase_cnt <= '0;    // Also recovers if sync_div shrinks
      end else begin
         phase_cnt <= phase_cnt + PH_W'(1);
      end
   end

   always_ff @(posedge clk_in or negedge user_reset_n) begin
      if (!user_reset_n) begin
         sync_cnt <= 2'b00;
      end else if (tick && rdy_sync) begin
         if (sync_mode)
            sync_cnt <= sync_cnt + 2'b01;      // Wraps
         else if (sync_cnt != 2'b11)
            sync_cnt <= sync_cnt + 2'b01;      // Stops at 3
      end
   end

   // Output register, updated on tick only
   always_ff @(posedge clk_in or negedge user_reset_n) begin
      if (!user_reset_n) begin
         dut_sync <= 1'b0;
      end else if (tick && sync_en) begin
         if (sync_mode)
            dut_sync <= sync_cnt[0];          // Square wave
         else
            dut_sync <= (sync_cnt == 2'b01);  // Single pulse
      end
   end

endmodule

`default_nettype wire

/* sync_ready_timer.sv */
// SYNC ready timer
// Settle counter after the sync clock is ready, and sticky dut_sync_rdy

`timescale 1ns/1ps
`default_nettype none

module sync_ready_timer
   import sync_ctrl_pkg::*;
(
   input  logic      drp_ref_clk,
   input  logic      user_reset_n,
   input  sync_cfg_t sync_cfg,
   input  logic      sync_en,
   output logic      dut_sync_rdy
);

   localparam logic [7:0] SETTLE_MAX = 8'hFF;

   logic [7:0] settle_cnt;

   always_ff @(posedge drp_ref_clk or negedge user_reset_n) begin
      if (!user_reset_n) begin
         settle_cnt   <= '0;
         dut_sync_rdy <= 1'b0;
      end else begin
         if (sync_cfg.sync_clk_rdy && (settle_cnt != SETTLE_MAX))
            settle_cnt <= settle_cnt + 8'd1;
         // No SYNC wanted, so nothing to wait for
         if (!sync_en || (settle_cnt == SETTLE_MAX))
            dut_sync_rdy <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* dut_sync_ctrl.sv */
// DUT SYNC controller top level
// Frequency meter, reconfiguration sequencer, pulse generator, ready timer

`timescale 1ns/1ps
`default_nettype none

module dut_sync_ctrl
   import sync_ctrl_pkg::*;
#(
   parameter int GATE_CYCLES  = 256,
   parameter int R1_MAX_COUNT = 20,    // Edge count thresholds
   parameter int R2_MAX_COUNT = 40,
   parameter int R3_MAX_COUNT = 64,
   parameter int R4_MAX_COUNT = 100,
   parameter int RANGE1_DIV   = 1,     // Divide ratio per range
   parameter int RANGE2_DIV   = 1,
   parameter int RANGE3_DIV   = 2,
   parameter int RANGE4_DIV   = 3,
   parameter int RANGE5_DIV   = 4,
   parameter int LOCK_CYCLES  = 16
) (
   input  logic   drp_ref_clk,
   input  logic   user_reset_n,
   input  logic   clk_in,
   input  logic   sync_en,
   input  logic   sync_mode,
   input  phase_t sync_phase,
   output logic   dut_sync,
   output logic   dut_sync_rdy
);

   meas_t     meas;
   sync_cfg_t sync_cfg;

   freq_range_meter #(
      .GATE_CYCLES  (GATE_CYCLES),
      .R1_MAX_COUNT (R1_MAX_COUNT),
      .R2_MAX_COUNT (R2_MAX_COUNT),
      .R3_MAX_COUNT (R3_MAX_COUNT),
      .R4_MAX_COUNT (R4_MAX_COUNT)
   ) u_meter (
      .drp_ref_clk  (drp_ref_clk),
      .user_reset_n (user_reset_n),
      .clk_in       (clk_in),
      .meas         (meas)
   );

   reconfig_seq #(
      .RANGE1_DIV   (RANGE1_DIV),
      .RANGE2_DIV   (RANGE2_DIV),
      .RANGE3_DIV   (RANGE3_DIV),
      .RANGE4_DIV   (RANGE4_DIV),
      .RANGE5_DIV   (RANGE5_DIV),
      .LOCK_CYCLES  (LOCK_CYCLES)
   ) u_seq (
      .drp_ref_clk  (drp_ref_clk),
      .user_reset_n (user_reset_n),
      .meas         (meas),
      .sync_cfg     (sync_cfg)
   );

   // clk_in domain
   sync_pulse_gen u_pulse (
      .clk_in       (clk_in),
      .user_reset_n (user_reset_n),
      .sync_cfg     (sync_cfg),
      .sync_en      (sync_en),
      .sync_mode    (sync_mode),
      .sync_phase   (sync_phase),
      .dut_sync     (dut_sync)
   );

   sync_ready_timer u_ready (
      .drp_ref_clk  (drp_ref_clk),
      .user_reset_n (user_reset_n),
      .sync_cfg     (sync_cfg),
      .sync_en      (sync_en),
      .dut_sync_rdy (dut_sync_rdy)
   );

endmodule

`default_nettype wire

/* tb_dut_sync_ctrl.sv */
// Testbench for the DUT SYNC controller
// Ref and clk_in clocks, per-run reset, stimulus, dut_sync edge capture,
// immediate and concurrent checks, per-test report

`timescale 1ns/1ps
`default_nettype none

module tb_dut_sync_ctrl
   import sync_ctrl_pkg::*;
();

   // Expected timing of the default configuration
   localparam int GATE_CYCLES    = 256;
   localparam int LOCK_CYCLES    = 16;
   localparam int SETTLE_CYCLES  = 255;
   localparam int RDY_LATEST     = 700;
   localparam int NUM_TESTS      = 7;
   localparam int TEST_BUDGET    = 3000;                    // Ref cycles per test
   localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_BUDGET;

   logic   drp_ref_clk  = 1'b0;
   logic   user_reset_n = 1'b1;
   logic   clk_in       = 1'b0;
   logic   sync_en      = 1'b0;
   logic   sync_mode    = 1'b0;
   phase_t sync_phase   = '0;
   logic   dut_sync;
   logic   dut_sync_rdy;

   logic   clk_in_run   = 1'b0;    // clk_in generator enable
   real    clk_half     = 20.0;
   int     ref_cyc      = 0;       // Ref cycles since reset release
   int     clk_idx      = 0;       // clk_in cycles since reset release
   int     total_cyc    = 0;
   logic   last_sync    = 1'b0;
   logic   rdy_seen     = 1'b0;
   int     edge_q[$];              // clk_in index of each dut_sync change
   string  test_name    = "";
   int     test_errs    = 0;
   int     err_count    = 0;
   int     tests_run    = 0;
   int     tests_failed = 0;
   int     rdy_cyc;
   int     rise_ph0;
   int     rise_ph5;
   int     phase_diff;

   dut_sync_ctrl u_dut (
      .drp_ref_clk  (drp_ref_clk),
      .user_reset_n (user_reset_n),
      .clk_in       (clk_in),
      .sync_en      (sync_en),
      .sync_mode    (sync_mode),
      .sync_phase   (sync_phase),
      .dut_sync     (dut_sync),
      .dut_sync_rdy (dut_sync_rdy)
   );

   //======================================================================
   // Clocks and counters
   //======================================================================
   always #4 drp_ref_clk = ~drp_ref_clk;

   // Restarts half a ns after a ref edge, so the two clocks never share an edge
   always begin
      if (!clk_in_run) begin
         clk_in = 1'b0;
         @(posedge clk_in_run);
         #0.5;
      end
      #(clk_half);
      clk_in = ~clk_in;
   end

   always @(posedge drp_ref_clk) begin
      if (!user_reset_n)
         ref_cyc <= 0;
      else
         ref_cyc <= ref_cyc + 1;
   end

   always @(posedge clk_in or negedge user_reset_n) begin
      if (!user_reset_n)
         clk_idx <= 0;
      else
         clk_idx <= clk_idx + 1;
   end

   // dut_sync is stable at the falling clk_in edge
   always @(negedge clk_in) begin
      if (user_reset_n && (dut_sync != last_sync))
         edge_q.push_back(clk_idx);
      last_sync = dut_sync;
   end

   always @(negedge drp_ref_clk) begin
      if (!user_reset_n)
         rdy_seen <= 1'b0;
      else if (dut_sync_rdy)
         rdy_seen <= 1'b1;
   end

   // Once high, dut_sync_rdy holds until reset
   rdy_sticky: assert property (@(negedge drp_ref_clk) disable iff (!user_reset_n)
                                rdy_seen |-> dut_sync_rdy)
      else report_failure("dut_sync_rdy fell after it had risen");

   always @(posedge drp_ref_clk) begin
      total_cyc <= total_cyc + 1;
      if (total_cyc >= TIMEOUT_CYCLES) begin
         $display("Timeout: no end of the run after %0d ref cycles", TIMEOUT_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   //======================================================================
   // Tasks
   //======================================================================
   task automatic report_mismatch(input string what, input int expected, input int actual);
      $display("[FAIL] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
      test_errs++;
   endtask

   task automatic report_failure(input string msg);
      $display("Error in %s: %s", test_name, msg);
      test_errs++;
   endtask

   // Stops clk_in, sets the quasi-static inputs in reset, holds reset 4 cycles
   task automatic start_run(input real half, input logic en, input logic mode,
                            input phase_t phase);
      @(posedge drp_ref_clk);
      clk_in_run <= 1'b0;
      repeat (20) @(posedge drp_ref_clk);   // Longer than any clk_in half period
      user_reset_n <= 1'b0;
      sync_en      <= en;
      sync_mode    <= mode;
      sync_phase   <= phase;
      clk_half      = half;
      clk_in_run   <= 1'b1;
      edge_q.delete();
      last_sync     = 1'b0;                 // dut_sync level after reset
      @(negedge drp_ref_clk);
      assert (dut_sync == 1'b0) else report_mismatch("dut_sync in reset", 0, int'(dut_sync));
      assert (dut_sync_rdy == 1'b0)
         else report_mismatch("dut_sync_rdy in reset", 0, int'(dut_sync_rdy));
      repeat (4) @(posedge drp_ref_clk);
      user_reset_n <= 1'b1;
   endtask

   // Every high and every low time equals one sync period
   task automatic check_square(input int period);
      assert (edge_q.size() >= 4) else report_mismatch("edge count (minimum)", 4, edge_q.size());
      for (int i = 1; i < edge_q.size(); i++) begin
         assert (edge_q[i] - edge_q[i-1] == period)
            else report_mismatch("edge spacing", period, edge_q[i] - edge_q[i-1]);
      end
   endtask

   task automatic finish_test();
      tests_run++;
      err_count += test_errs;
      if (test_errs == 0) begin
         $display("%-16s ok", test_name);
      end else begin
         tests_failed++;
         $display("%-16s FAILED with %0d errors", test_name, test_errs);
      end
      test_errs = 0;
   endtask

   task automatic run_periodic(input string name, input real half, input int period);
      test_name = name;
      start_run(half, 1'b1, 1'b1, 3'd0);
      repeat (1500) @(negedge drp_ref_clk);
      check_square(period);
      finish_test();
   endtask

   //======================================================================
   // Test sequence
   //======================================================================
   initial begin
      test_name = "rdy_no_sync";
      start_run(64.0, 1'b0, 1'b0, 3'd0);
      repeat (600) begin
         @(negedge drp_ref_clk);
         if (ref_cyc >= 2)
            assert (dut_sync_rdy == 1'b1)
               else report_mismatch("dut_sync_rdy", 1, int'(dut_sync_rdy));
         assert (dut_sync == 1'b0) else report_mismatch("dut_sync", 0, int'(dut_sync));
      end
      assert (edge_q.size() == 0) else report_mismatch("dut_sync edges", 0, edge_q.size());
      finish_test();

      test_name = "settle_delay";
      start_run(20.0, 1'b1, 1'b0, 3'd0);
      rdy_cyc = -1;
      repeat (800) begin
         @(negedge drp_ref_clk);
         if ((rdy_cyc < 0) && dut_sync_rdy)
            rdy_cyc = ref_cyc;
      end
      assert (rdy_cyc >= GATE_CYCLES + LOCK_CYCLES + SETTLE_CYCLES)
         else report_mismatch("rdy rise cycle (minimum)",
                              GATE_CYCLES + LOCK_CYCLES + SETTLE_CYCLES, rdy_cyc);
      assert ((rdy_cyc >= 0) && (rdy_cyc < RDY_LATEST))
         else report_mismatch("rdy rise cycle (maximum)", RDY_LATEST - 1, rdy_cyc);
      finish_test();

      // 40 ns is range 3, divide ratio 2, so 16 clk_in cycles per sync period
      test_name = "one_shot";
      start_run(20.0, 1'b1, 1'b0, 3'd0);
      repeat (2000) @(negedge drp_ref_clk);
      assert (edge_q.size() == 2) else report_mismatch("dut_sync edges", 2, edge_q.size());
      if (edge_q.size() == 2)
         assert (edge_q[1] - edge_q[0] == 16)
            else report_mismatch("pulse width", 16, edge_q[1] - edge_q[0]);
      finish_test();

      run_periodic("periodic_128ns", 64.0, 8);
      run_periodic("periodic_40ns", 20.0, 16);
      run_periodic("periodic_18ns", 9.0, 32);

      test_name = "phase_step";
      start_run(20.0, 1'b1, 1'b1, 3'd0);
      repeat (1200) @(negedge drp_ref_clk);
      rise_ph0 = (edge_q.size() > 0) ? edge_q[0] : -1;
      start_run(20.0, 1'b1, 1'b1, 3'd5);
      repeat (1200) @(negedge drp_ref_clk);
      rise_ph5 = (edge_q.size() > 0) ? edge_q[0] : -1;
      phase_diff = ((rise_ph5 - rise_ph0) % 16 + 16) % 16;
      assert ((rise_ph0 >= 0) && (rise_ph5 >= 0))
         else report_failure("no rising dut_sync edge in one of the two runs");
      assert (phase_diff == (5 * 2) % 16)        // Step 5 of ratio 2
         else report_mismatch("rise offset mod 16", (5 * 2) % 16, phase_diff);
      finish_test();

      $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
               tests_run, tests_failed, err_count);
      if (tests_failed == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
sync_ctrl_pkg.sv
freq_range_meter.sv
reconfig_seq.sv
sync_pulse_gen.sv
sync_ready_timer.sv
dut_sync_ctrl.sv
tb_dut_sync_ctrl.sv

/* Makefile */
BIN := obj_dir/Vtb_dut_sync_ctrl

.PHONY: all run clean

all: run

$(BIN): files.f $(wildcard *.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_dut_sync_ctrl -f files.f

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
